// ==== run_verilator.sh ====
#!/bin/sh
# Build the execute slice testbench with Verilator and run it from the project root.
# The exit status is the simulator's: nonzero after a $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module alu_subsystem_tb -Mdir obj_dir \
    && ./obj_dir/Valu_subsystem_tb \
    || { echo "Simulation run failed"; exit 1; }

// ==== src/alu_pkg.sv ====
// Shared types for the execute slice, referenced by scoped name from every RTL and testbench file
package alu_pkg;

    // ================================================
    // Data path widths
    // ================================================

    // Width of one RV32I register, immediate or result word
    localparam int DATA_WIDTH = 32;

    // Width of the ALU micro-operation code
    localparam int UOP_WIDTH = 4;

    // Sequence tags wrap modulo 256
    localparam int TAG_WIDTH = 8;

    typedef logic [DATA_WIDTH-1:0] data_word_t;

    typedef logic [TAG_WIDTH-1:0] alu_tag_t;

    // ================================================
    // Micro-operation encoding
    // ================================================

    // Codes run from 0 to 15 in this order and the stimulus file relies on them
    // Branch codes return their outcome as 0 or 1 instead of a target address
    typedef enum logic [UOP_WIDTH-1:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLT  = 4'd5,
        SLTU = 4'd6,
        SLL  = 4'd7,
        SRL  = 4'd8,
        SRA  = 4'd9,
        BEQ  = 4'd10,
        BNE  = 4'd11,
        BLT  = 4'd12,
        BLTU = 4'd13,
        BGE  = 4'd14,
        BGEU = 4'd15
    } alu_uop_t;

    // ================================================
    // Queued request
    // ================================================

    // One issued request as it sits in the queue, 76 bits in total
    // Operand B is already resolved to either rs2 or the immediate
    typedef struct packed {
        alu_uop_t   operation;
        data_word_t operand_a;
        data_word_t operand_b;
        alu_tag_t   tag;
    } alu_request_t;

endpackage : alu_pkg

// ==== src/alu_subsystem_top.sv ====
// Top level of the execute slice, connecting producer, request queue and consumer
`timescale 1ns/1ps

module alu_subsystem_top #(
    // Number of requests the queue can hold while writeback stalls
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk_i,
    input  logic                rst_i,

    // Instruction strobe and fields
    input  logic                issue_valid_i,
    input  alu_pkg::alu_uop_t   operation_i,
    input  alu_pkg::data_word_t rs1_i,
    input  alu_pkg::data_word_t rs2_i,
    input  alu_pkg::data_word_t imm_i,
    input  logic                use_imm_i,

    // Writeback back-pressure
    input  logic                stall_i,

    // Results and queue status
    output logic                result_valid_o,
    output alu_pkg::data_word_t result_o,
    output alu_pkg::alu_tag_t   result_tag_o,
    output logic                overflow_o,
    output logic                queue_full_o
);

    // Producer to queue
    logic                  req_valid;
    alu_pkg::alu_request_t req_payload;

    // Queue to consumer
    logic                  queue_empty;
    logic                  queue_pop;
    alu_pkg::alu_request_t queue_head;

    // ================================================
    // Producer
    // ================================================

    operand_issue u_operand_issue (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .operation_i   (operation_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .imm_i         (imm_i),
        .use_imm_i     (use_imm_i),
        .req_valid_o   (req_valid),
        .req_payload_o (req_payload)
    );

    // ================================================
    // Request queue
    // ================================================

    request_fifo #(
        .PAYLOAD_T (alu_pkg::alu_request_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_request_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (req_valid),
        .push_data_i (req_payload),
        .pop_i       (queue_pop),
        .pop_data_o  (queue_head),
        .empty_o     (queue_empty),
        .full_o      (queue_full_o),
        .overflow_o  (overflow_o)
    );

    // ================================================
    // Consumer
    // ================================================

    execute_stage u_execute_stage (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .stall_i        (stall_i),
        .empty_i        (queue_empty),
        .head_i         (queue_head),
        .pop_o          (queue_pop),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_tag_o   (result_tag_o)
    );

endmodule : alu_subsystem_top

// ==== src/arithmetic_logic_unit.sv ====
// Combinational RV32I ALU evaluating one micro-operation on two operand words
`timescale 1ns/1ps

module arithmetic_logic_unit (
    // Operand B already carries the immediate where the instruction has one
    input  alu_pkg::data_word_t operand_a_i,
    input  alu_pkg::data_word_t operand_b_i,

    // Operation selecting the result
    input  alu_pkg::alu_uop_t   operation_i,

    output alu_pkg::data_word_t result_o
);

    // ================================================
    // Adder and subtractor
    // ================================================

    alu_pkg::data_word_t add_result;
    alu_pkg::data_word_t sub_result;

    assign add_result = operand_a_i + operand_b_i;
    assign sub_result = operand_a_i - operand_b_i;

    // ================================================
    // Comparators
    // ================================================

    // Signed compares treat both words as two's complement
    logic less_than_s;
    logic greater_equal_s;

    assign less_than_s     = $signed(operand_a_i) < $signed(operand_b_i);
    assign greater_equal_s = $signed(operand_a_i) >= $signed(operand_b_i);

    // Unsigned compares for SLTU, BLTU and BGEU
    logic less_than_u;
    logic greater_equal_u;

    assign less_than_u     = operand_a_i < operand_b_i;
    assign greater_equal_u = operand_a_i >= operand_b_i;

    logic equal;

    assign equal = (operand_a_i == operand_b_i);

    // ================================================
    // Shifter
    // ================================================

    // Only the low five bits count, larger amounts wrap around
    logic [4:0] shift_amount;

    alu_pkg::data_word_t sll_result;
    alu_pkg::data_word_t srl_result;
    alu_pkg::data_word_t sra_result;

    assign shift_amount = operand_b_i[4:0];

    assign sll_result = operand_a_i << shift_amount;
    assign srl_result = operand_a_i >> shift_amount;

    // Sign bit is replicated into the vacated positions
    assign sra_result = $signed(operand_a_i) >>> shift_amount;

    // ================================================
    // Result selection
    // ================================================

    // Compare and branch outcomes are zero-extended single bits
    always_comb begin
        case (operation_i)
            alu_pkg::ADD:  result_o = add_result;
            alu_pkg::SUB:  result_o = sub_result;
            alu_pkg::AND:  result_o = operand_a_i & operand_b_i;
            alu_pkg::OR:   result_o = operand_a_i | operand_b_i;
            alu_pkg::XOR:  result_o = operand_a_i ^ operand_b_i;
            alu_pkg::SLT:  result_o = alu_pkg::data_word_t'(less_than_s);
            alu_pkg::SLTU: result_o = alu_pkg::data_word_t'(less_than_u);
            alu_pkg::SLL:  result_o = sll_result;
            alu_pkg::SRL:  result_o = srl_result;
            alu_pkg::SRA:  result_o = sra_result;
            alu_pkg::BEQ:  result_o = alu_pkg::data_word_t'(equal);
            alu_pkg::BNE:  result_o = alu_pkg::data_word_t'(!equal);
            alu_pkg::BLT:  result_o = alu_pkg::data_word_t'(less_than_s);
            alu_pkg::BLTU: result_o = alu_pkg::data_word_t'(less_than_u);
            alu_pkg::BGE:  result_o = alu_pkg::data_word_t'(greater_equal_s);
            alu_pkg::BGEU: result_o = alu_pkg::data_word_t'(greater_equal_u);
            default:       result_o = '0;
        endcase
    end

endmodule : arithmetic_logic_unit

// ==== src/execute_stage.sv ====
// Consumer stage that pops queued requests, evaluates them in the ALU and registers tagged results
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Writeback back-pressure, a plain level
    input  logic                  stall_i,

    // Queue head and its empty level
    input  logic                  empty_i,
    input  alu_pkg::alu_request_t head_i,
    output logic                  pop_o,

    // Registered result with its sequence tag
    output logic                  result_valid_o,
    output alu_pkg::data_word_t   result_o,
    output alu_pkg::alu_tag_t     result_tag_o
);

    // ================================================
    // Pop control
    // ================================================

    // Take the head whenever there is one and writeback is free
    assign pop_o = !empty_i && !stall_i;

    // ================================================
    // Evaluation
    // ================================================

    alu_pkg::data_word_t alu_result;

    // The head is evaluated every cycle, the pop decides whether it is kept
    arithmetic_logic_unit u_alu (
        .operand_a_i (head_i.operand_a),
        .operand_b_i (head_i.operand_b),
        .operation_i (head_i.operation),
        .result_o    (alu_result)
    );

    // ================================================
    // Result register
    // ================================================

    // Valid is control state and follows the pop by one cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= pop_o;
        end
    end

    // Result and tag hold their last value between pops
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            result_o     <= alu_result;
            result_tag_o <= head_i.tag;
        end
    end

    // ================================================
    // Assertions
    // ================================================

    // A valid result needs a queued head and a free writeback in the cycle before it
    assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_o |-> $past(!empty_i && !stall_i))
        else $error("execute_stage result valid without a preceding pop");

endmodule : execute_stage

// ==== src/operand_issue.sv ====
// Producer stage that resolves operand B, tags each strobed instruction and registers the request
`timescale 1ns/1ps

module operand_issue (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Instruction strobe and its fields
    input  logic                  issue_valid_i,
    input  alu_pkg::alu_uop_t     operation_i,
    input  alu_pkg::data_word_t   rs1_i,
    input  alu_pkg::data_word_t   rs2_i,
    input  alu_pkg::data_word_t   imm_i,
    input  logic                  use_imm_i,

    // Registered request toward the queue push side
    output logic                  req_valid_o,
    output alu_pkg::alu_request_t req_payload_o
);

    // ================================================
    // Operand selection
    // ================================================

    // Operand B is the immediate for I-type forms, otherwise the second register
    alu_pkg::data_word_t operand_b;

    assign operand_b = use_imm_i ? imm_i : rs2_i;

    // ================================================
    // Sequence tag counter
    // ================================================

    // Tag given to the next strobed instruction
    alu_pkg::alu_tag_t tag_count;

    // The counter moves on every strobe, even if the queue later drops the request,
    // so a lost request shows up as a hole in the tag sequence
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tag_count   <= '0;
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= issue_valid_i;

            if (issue_valid_i) begin
                tag_count <= tag_count + alu_pkg::alu_tag_t'(1);
            end
        end
    end

    // ================================================
    // Request register
    // ================================================

    // Payload is only captured on a strobe and is qualified by req_valid_o
    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            req_payload_o.operation <= operation_i;
            req_payload_o.operand_a <= rs1_i;
            req_payload_o.operand_b <= operand_b;
            req_payload_o.tag       <= tag_count;
        end
    end

endmodule : operand_issue

// ==== src/request_fifo.sv ====
// Circular request queue with a type-parameterised payload, used between producer and consumer
`timescale 1ns/1ps

module request_fifo #(
    parameter type PAYLOAD_T = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_i,

    // Push side, a push while full is lost unless the same cycle pops
    input  logic     push_i,
    input  PAYLOAD_T push_data_i,

    // Pop side, the head is presented combinationally
    input  logic     pop_i,
    output PAYLOAD_T pop_data_o,

    // Occupancy levels and the sticky drop flag
    output logic     empty_o,
    output logic     full_o,
    output logic     overflow_o
);

    // Pointers need at least one bit even for a single entry
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // The count must be able to hold DEPTH itself
    localparam int CNT_W = $clog2(DEPTH + 1);

    // ================================================
    // Storage and pointers
    // ================================================

    PAYLOAD_T           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    logic push_ok;
    logic pop_ok;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

    // A full queue still takes a push when an entry leaves in the same cycle
    assign push_ok = push_i && (!full_o || pop_i);
    assign pop_ok  = pop_i && !empty_o;

    assign pop_data_o = mem[rd_ptr];

    // Entries are written without reset, validity comes from the count
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // ================================================
    // Control state
    // ================================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end

            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            // Net occupancy change for this cycle
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // Sticky until reset so a drop is never missed
            if (push_i && !push_ok) begin
                overflow_o <= 1'b1;
            end
        end
    end

    // ================================================
    // Assertions
    // ================================================

    // The consumer must respect the empty level
    assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o)
        else $error("request_fifo popped while empty");

    // Occupancy bookkeeping stays within the storage
    assert property (@(posedge clk_i) disable iff (rst_i) count <= CNT_W'(DEPTH))
        else $error("request_fifo count exceeds DEPTH");

endmodule : request_fifo

// ==== tb/alu_stimulus.txt ====
// Columns: operation code, rs1, rs2, immediate, use-immediate flag, expected result (all hex)
// Operation codes: 0 ADD 1 SUB 2 AND 3 OR 4 XOR 5 SLT 6 SLTU 7 SLL 8 SRL 9 SRA a BEQ .. f BGEU
0 00000005 00000007 00000000 0 0000000c
0 ffffffff 00000001 00000000 0 00000000
1 00000003 00000005 00000000 0 fffffffe
2 f0f0f0f0 ff00ff00 00000000 0 f000f000
3 f0f0f0f0 0f0f0000 00000000 0 fffff0f0
4 aaaa5555 ffff0000 00000000 0 55555555
5 ffffffff 00000001 00000000 0 00000001
6 ffffffff 00000001 00000000 0 00000000
7 00000001 00000024 00000000 0 00000010
8 80000000 0000001f 00000000 0 00000001
9 80000000 00000004 00000000 0 f8000000
9 fffffff0 00000021 00000000 0 fffffff8
a 12345678 12345678 00000000 0 00000001
b 12345678 12345678 00000000 0 00000000
c 80000000 7fffffff 00000000 0 00000001
d 80000000 7fffffff 00000000 0 00000000
e 7fffffff 80000000 00000000 0 00000001
f 7fffffff 80000000 00000000 0 00000000
0 00000010 deadbeef fffffff0 1 00000000
7 00000003 00000001 00000004 1 00000030
4 0000ffff 12345678 ffffffff 1 ffff0000
6 00000005 00000000 00000006 1 00000001
e ffffffff 00000000 00000000 0 00000000
8 80000001 00000020 00000000 0 80000001

// ==== tb/alu_subsystem_tb.sv ====
// Self-checking testbench for the execute slice, reads the stimulus file and runs as simulation top
`timescale 1ns/1ps

module alu_subsystem_tb;

    // ================================================
    // Test parameters
    // ================================================

    localparam int FIFO_DEPTH    = 4;
    localparam int NUM_LINES     = 24;
    localparam int FIELDS        = 6;
    localparam int RANDOM_PASSES = 2;

    // Every request the sequence issues, including the one the queue drops
    localparam int TOTAL_REQUESTS  = NUM_LINES * (1 + RANDOM_PASSES) + FIFO_DEPTH + 2;
    localparam int WATCHDOG_CYCLES = TOTAL_REQUESTS * 64 + 200;

    // DUT inputs
    logic                clk_i;
    logic                rst_i;
    logic                issue_valid_i;
    alu_pkg::alu_uop_t   operation_i;
    alu_pkg::data_word_t rs1_i;
    alu_pkg::data_word_t rs2_i;
    alu_pkg::data_word_t imm_i;
    logic                use_imm_i;
    logic                stall_i;

    // DUT outputs
    logic                result_valid_o;
    alu_pkg::data_word_t result_o;
    alu_pkg::alu_tag_t   result_tag_o;
    logic                overflow_o;
    logic                queue_full_o;

    // Six words per line: operation, rs1, rs2, immediate, use-immediate flag, expected result
    logic [31:0] stim_mem [NUM_LINES * FIELDS];

    // Scoreboard, one entry per request that the queue is expected to keep
    alu_pkg::data_word_t exp_result_q [$];
    alu_pkg::alu_tag_t   exp_tag_q [$];
    int                  exp_edge_q [$];

    // Tags are counted here independently of the DUT
    alu_pkg::alu_tag_t next_tag = '0;

    // Only the driver changes issued_count, only the monitor changes received_count
    int issued_count   = 0;
    int received_count = 0;
    int cycle_count    = 0;

    logic [31:0] lfsr_state = 32'hf5f4;

    alu_subsystem_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .issue_valid_i  (issue_valid_i),
        .operation_i    (operation_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .imm_i          (imm_i),
        .use_imm_i      (use_imm_i),
        .stall_i        (stall_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_tag_o   (result_tag_o),
        .overflow_o     (overflow_o),
        .queue_full_o   (queue_full_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Edge index, read before its update so every process sees the same value at an edge
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    // ================================================
    // Helpers and compare tasks
    // ================================================

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 32'h8020_0003;
        end
        return shifted;
    endfunction

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_result(input alu_pkg::data_word_t got, input alu_pkg::data_word_t want);
        if (got !== want) begin
            $display("** Error at %0t: result_o = %h, expected %h", $time, got, want);
            stop_run();
        end
    endtask

    task automatic check_tag(input alu_pkg::alu_tag_t got, input alu_pkg::alu_tag_t want);
        if (got !== want) begin
            $display("** Error at %0t: result_tag_o = %0d, expected %0d", $time, got, want);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string name);
        if (got !== want) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic check_latency(input int got, input int want);
        if (got != want) begin
            $display("** Error at %0t: result_valid_o latency = %0d, expected %0d",
                     $time, got, want);
            stop_run();
        end
    endtask

    // Drives one file line as a strobe, called right after a rising edge
    // A request the queue should drop still uses up a tag but gets no scoreboard entry
    task automatic issue_line(input int line, input bit timed, input bit kept);
        int base;
        base = line * FIELDS;
        issue_valid_i <= 1'b1;
        operation_i   <= alu_pkg::alu_uop_t'(stim_mem[base][3:0]);
        rs1_i         <= stim_mem[base + 1];
        rs2_i         <= stim_mem[base + 2];
        imm_i         <= stim_mem[base + 3];
        use_imm_i     <= stim_mem[base + 4][0];
        if (kept) begin
            exp_result_q.push_back(stim_mem[base + 5]);
            exp_tag_q.push_back(next_tag);
            // The DUT samples the strobe at the next edge
            exp_edge_q.push_back(timed ? cycle_count + 1 : -1);
            issued_count = issued_count + 1;
        end
        next_tag = next_tag + alu_pkg::alu_tag_t'(1);
    endtask

    task automatic wait_drained();
        while (received_count != issued_count) begin
            @(posedge clk_i);
        end
    endtask

    // ================================================
    // Result monitor
    // ================================================

    always @(posedge clk_i) begin : result_monitor
        alu_pkg::data_word_t want_result;
        alu_pkg::alu_tag_t   want_tag;
        int                  want_edge;
        if (!rst_i && result_valid_o) begin
            if (exp_result_q.size() == 0) begin
                $display("A result arrived at %0t with no request outstanding", $time);
                stop_run();
            end else begin
                want_result = exp_result_q.pop_front();
                want_tag    = exp_tag_q.pop_front();
                want_edge   = exp_edge_q.pop_front();
                check_result(result_o, want_result);
                check_tag(result_tag_o, want_tag);
                // The valid was set at the previous edge, two edges after the strobe was taken
                if (want_edge >= 0) begin
                    check_latency(cycle_count - 1 - want_edge, 2);
                end
                received_count <= received_count + 1;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Results stopped arriving before the test sequence finished");
        stop_run();
    end

    // ================================================
    // Test sequence
    // ================================================

    initial begin : main_sequence
        int idx;
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        operation_i   = alu_pkg::ADD;
        rs1_i         = '0;
        rs2_i         = '0;
        imm_i         = '0;
        use_imm_i     = 1'b0;
        stall_i       = 1'b0;
        $readmemh("tb/alu_stimulus.txt", stim_mem);

        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;

        // Quiet outputs after reset with no strobes
        repeat (8) begin
            @(posedge clk_i);
            check_flag(result_valid_o, 1'b0, "result_valid_o");
            check_flag(overflow_o, 1'b0, "overflow_o");
            check_flag(queue_full_o, 1'b0, "queue_full_o");
        end

        // Every line alone, so each result shows the unstalled latency
        for (int line = 0; line < NUM_LINES; line++) begin
            @(posedge clk_i);
            issue_line(line, 1'b1, 1'b1);
            @(posedge clk_i);
            issue_valid_i <= 1'b0;
            wait_drained();
        end

        // Back-to-back strobes under random stall, outstanding work kept below the depth
        idx = 0;
        while (idx < RANDOM_PASSES * NUM_LINES) begin
            @(posedge clk_i);
            lfsr_state = lfsr_next(lfsr_state);
            stall_i <= lfsr_state[0];
            if (issued_count - received_count < FIFO_DEPTH) begin
                issue_line(idx % NUM_LINES, 1'b0, 1'b1);
                idx = idx + 1;
            end else begin
                issue_valid_i <= 1'b0;
            end
        end
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
        stall_i       <= 1'b0;
        wait_drained();
        check_flag(overflow_o, 1'b0, "overflow_o");

        // One request more than the queue holds while the stall is held
        @(posedge clk_i);
        stall_i <= 1'b1;
        for (int n = 0; n <= FIFO_DEPTH; n++) begin
            issue_line(n, 1'b0, n < FIFO_DEPTH);
            @(posedge clk_i);
        end
        issue_valid_i <= 1'b0;
        repeat (3) @(posedge clk_i);
        check_flag(queue_full_o, 1'b1, "queue_full_o");
        check_flag(overflow_o, 1'b1, "overflow_o");

        stall_i <= 1'b0;
        wait_drained();

        // Any extra result here would be caught by the monitor
        repeat (8) begin
            @(posedge clk_i);
            check_flag(overflow_o, 1'b1, "overflow_o");
            check_flag(queue_full_o, 1'b0, "queue_full_o");
        end

        // The next tag skips the dropped request
        issue_line(0, 1'b1, 1'b1);
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
        wait_drained();
        repeat (4) @(posedge clk_i);

        $display("All checks passed");
        $finish;
    end

endmodule : alu_subsystem_tb

// ==== vlog.f ====
src/alu_pkg.sv
src/operand_issue.sv
src/request_fifo.sv
src/arithmetic_logic_unit.sv
src/execute_stage.sv
src/alu_subsystem_top.sv
tb/alu_subsystem_tb.sv
